// File: adc_capture.f
source/capture_pkg.sv
source/capture_ctrl.sv
source/ram_arbiter.sv
source/sample_ram.sv
source/readout_engine.sv
source/adc_capture_top.sv
verif/tb_adc_capture.sv

// File: run_sim.sh
#!/bin/sh
# build and run the capture buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_adc_capture \
	-f adc_capture.f -o sim_adc_capture > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_adc_capture > sim.log 2>&1

grep -q "Simulation finished: FAIL" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"
exit 0

// File: source/adc_capture_top.sv
// top level of the two-channel adc capture buffer
// capture controller, readout engine, arbiter and memory
`default_nettype none

module adc_capture_top import capture_pkg::*; (
	input  wire     data_clk_div,
	input  wire     rst,
	input  SAMPLE_T adc0_data,
	input  SAMPLE_T adc1_data,
	input  wire     capture_enable,
	input  wire     rd_req_valid,
	input  ADDR_T   rd_addr,
	input  wire     rsp_credit,
	output logic    capture_done,
	output logic    rd_req_ready,
	output logic    rsp_valid,
	output WORD_T   rsp_data
);

	logic wr_req;
	ADDR_T wr_addr;
	WORD_T wr_data;

	logic rd_mem_req;
	ADDR_T rd_mem_addr;
	logic rd_mem_grant;

	logic mem_en;
	logic mem_we;
	ADDR_T mem_addr;
	WORD_T mem_wdata;
	WORD_T mem_rdata;

	capture_ctrl i_capture_ctrl (
		.data_clk_div  (data_clk_div),
		.rst           (rst),
		.capture_enable(capture_enable),
		.adc0_data     (adc0_data),
		.adc1_data     (adc1_data),
		.wr_req        (wr_req),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.capture_done  (capture_done)
	);

	readout_engine i_readout_engine (
		.data_clk_div(data_clk_div),
		.rst         (rst),
		.rd_req_valid(rd_req_valid),
		.rd_addr     (rd_addr),
		.rsp_credit  (rsp_credit),
		.rd_mem_grant(rd_mem_grant),
		.mem_rdata   (mem_rdata),
		.rd_req_ready(rd_req_ready),
		.rd_mem_req  (rd_mem_req),
		.rd_mem_addr (rd_mem_addr),
		.rsp_valid   (rsp_valid),
		.rsp_data    (rsp_data)
	);

	// writer and reader share the one memory port
	ram_arbiter i_ram_arbiter (
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.rd_mem_req  (rd_mem_req),
		.rd_mem_addr (rd_mem_addr),
		.rd_mem_grant(rd_mem_grant),
		.mem_en      (mem_en),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata)
	);

	sample_ram i_sample_ram (
		.data_clk_div(data_clk_div),
		.mem_en      (mem_en),
		.mem_we      (mem_we),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

// File: source/capture_ctrl.sv
// capture controller
// enable synchronizer and edge detect, write address counter, done flag
`default_nettype none

module capture_ctrl import capture_pkg::*; (
	input  wire     data_clk_div,
	input  wire     rst,
	input  wire     capture_enable,
	input  SAMPLE_T adc0_data,
	input  SAMPLE_T adc1_data,
	output logic    wr_req,
	output ADDR_T   wr_addr,
	output WORD_T   wr_data,
	output logic    capture_done
);

	logic [SYNC_STAGES-1:0] enable_sync_q;
	logic enable_sync;
	logic enable_r;
	logic rise;
	logic fall;

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			enable_sync_q <= '0;
			enable_r <= 1'b0;
		end else begin
			enable_sync_q <= {enable_sync_q[SYNC_STAGES-2:0], capture_enable};
			enable_r <= enable_sync;
		end
	end

	assign enable_sync = enable_sync_q[SYNC_STAGES-1];
	assign rise = enable_sync & ~enable_r;
	assign fall = ~enable_sync & enable_r;

	// sample pair registered on every edge
	always_ff @(posedge data_clk_div) begin
		wr_data <= {adc0_data, adc1_data};
	end

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			wr_req <= 1'b0;
			wr_addr <= '0;
			capture_done <= 1'b0;
		end else if (rise) begin
			// new capture overwrites from address 0
			wr_req <= 1'b1;
			wr_addr <= '0;
			capture_done <= 1'b0;
		end else if (fall) begin
			wr_req <= 1'b0;
			wr_addr <= '0;
			capture_done <= 1'b0;
		end else if (wr_req) begin
			if (wr_addr == ADDR_T'(DEPTH - 1)) begin
				wr_req <= 1'b0;
				capture_done <= 1'b1;
			end else begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	// a running capture only stops at the last address or on an enable drop
	assert property (@(posedge data_clk_div) disable iff (rst)
		$fell(wr_req) |-> capture_done || $past(fall) || $past(rst))
		else $error("capture stopped early without an enable drop");

endmodule

`default_nettype wire

// File: source/capture_pkg.sv
// shared widths, sizes and types of the two-channel capture buffer
`default_nettype none

package capture_pkg;

	// one adc channel sample
	localparam int SAMPLE_W = 16;
	typedef logic [SAMPLE_W-1:0] SAMPLE_T;

	// channel 0 in the upper half of a stored word
	typedef logic [2*SAMPLE_W-1:0] WORD_T;

	// words per capture
	localparam int DEPTH = 1024;
	typedef logic [$clog2(DEPTH)-1:0] ADDR_T;

	// flops in the enable synchronizer
	localparam int SYNC_STAGES = 3;

	// response credits held after reset
	localparam int RSP_CREDITS = 4;
	typedef logic [$clog2(RSP_CREDITS+1)-1:0] CREDIT_T;

endpackage

`default_nettype wire

// File: source/ram_arbiter.sv
// memory port arbiter
// capture writer has fixed priority over the host reader
`default_nettype none

module ram_arbiter import capture_pkg::*; (
	input  wire   wr_req,
	input  ADDR_T wr_addr,
	input  WORD_T wr_data,
	input  wire   rd_mem_req,
	input  ADDR_T rd_mem_addr,
	output logic  rd_mem_grant,
	output logic  mem_en,
	output logic  mem_we,
	output ADDR_T mem_addr,
	output WORD_T mem_wdata
);

	always_comb begin
		// sample stream cannot stall so the writer always wins
		rd_mem_grant = rd_mem_req & ~wr_req;
		mem_en = wr_req | rd_mem_req;
		mem_we = wr_req;
		if (wr_req) begin
			mem_addr = wr_addr;
		end else begin
			mem_addr = rd_mem_addr;
		end
		mem_wdata = wr_data;

		assert (!(rd_mem_grant && mem_we))
			else $error("read granted during a capture write");
	end

endmodule

`default_nettype wire

// File: source/readout_engine.sv
// host readout engine
// one request slot, memory read request and credit-controlled response
`default_nettype none

module readout_engine import capture_pkg::*; (
	input  wire   data_clk_div,
	input  wire   rst,
	input  wire   rd_req_valid,
	input  ADDR_T rd_addr,
	input  wire   rsp_credit,
	input  wire   rd_mem_grant,
	input  WORD_T mem_rdata,
	output logic  rd_req_ready,
	output logic  rd_mem_req,
	output ADDR_T rd_mem_addr,
	output logic  rsp_valid,
	output WORD_T rsp_data
);

	logic slot_valid;
	ADDR_T slot_addr;
	CREDIT_T credits;
	logic req_accept;

	// slot stays busy until the response has gone out
	assign rd_req_ready = ~slot_valid & (credits != '0);
	assign req_accept = rd_req_valid & rd_req_ready;

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			slot_valid <= 1'b0;
		end else if (req_accept) begin
			slot_valid <= 1'b1;
		end else if (rsp_valid) begin
			slot_valid <= 1'b0;
		end
	end

	always_ff @(posedge data_clk_div) begin
		if (req_accept) begin
			slot_addr <= rd_addr;
		end
	end

	// request drops once granted
	assign rd_mem_req = slot_valid & ~rsp_valid;
	assign rd_mem_addr = slot_addr;

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= rd_mem_req & rd_mem_grant;
		end
	end

	// ram output register holds the word
	assign rsp_data = mem_rdata;

	always_ff @(posedge data_clk_div) begin
		if (rst) begin
			credits <= CREDIT_T'(RSP_CREDITS);
		end else begin
			credits <= credits - CREDIT_T'(rsp_valid) + CREDIT_T'(rsp_credit);
		end
	end

	assert property (@(posedge data_clk_div) disable iff (rst)
		rsp_valid |-> credits != '0)
		else $error("response sent without a credit");

	// consumer returned more credits than it was given
	assert property (@(posedge data_clk_div) disable iff (rst)
		credits <= CREDIT_T'(RSP_CREDITS))
		else $error("credit count above the reset value");

endmodule

`default_nettype wire

// File: source/sample_ram.sv
// single-port capture memory with registered read
`default_nettype none

module sample_ram import capture_pkg::*; (
	input  wire   data_clk_div,
	input  wire   mem_en,
	input  wire   mem_we,
	input  ADDR_T mem_addr,
	input  WORD_T mem_wdata,
	output WORD_T mem_rdata
);

	WORD_T mem [0:DEPTH-1];

	// maps onto one block ram port
	always_ff @(posedge data_clk_div) begin
		if (mem_en) begin
			if (mem_we) begin
				mem[mem_addr] <= mem_wdata;
			end else begin
				mem_rdata <= mem[mem_addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_adc_capture.sv
// testbench for the two-channel adc capture buffer
// random samples, memory and credit model, compare tasks and timeout
`default_nettype none

module tb_adc_capture import capture_pkg::*; ();

	localparam logic [31:0] SEED = 32'h8072;
	localparam int N_CAPTURES = 4;
	localparam int N_READS = 3200;
	localparam int N_BUSY_READS = 16;
	localparam int TIMEOUT_CYCLES = N_CAPTURES * 1100 + N_READS * 20 + 2000;

	logic data_clk_div;
	logic rst;
	SAMPLE_T adc0_data = '0;
	SAMPLE_T adc1_data = '0;
	logic capture_enable;
	logic rd_req_valid;
	ADDR_T rd_addr;
	logic rsp_credit = 1'b0;
	logic capture_done;
	logic rd_req_ready;
	logic rsp_valid;
	WORD_T rsp_data;

	// capture model
	WORD_T model_mem [DEPTH];
	WORD_T prev_mem [DEPTH];
	logic [2:0] en_hist;
	logic en_delayed;
	logic en_delayed_prev;
	int wr_ptr;
	logic last_written;
	logic model_done;

	// read and credit model
	ADDR_T addr_fifo [$];
	int credit_due [$];
	int model_credits;
	int accepted;
	int responses;
	int unreturned;
	logic hold_credits;
	logic loose_check;
	string rd_name;
	logic in_reset;
	int cycle;

	adc_capture_top i_adc_capture_top (
		.data_clk_div  (data_clk_div),
		.rst           (rst),
		.adc0_data     (adc0_data),
		.adc1_data     (adc1_data),
		.capture_enable(capture_enable),
		.rd_req_valid  (rd_req_valid),
		.rd_addr       (rd_addr),
		.rsp_credit    (rsp_credit),
		.capture_done  (capture_done),
		.rd_req_ready  (rd_req_ready),
		.rsp_valid     (rsp_valid),
		.rsp_data      (rsp_data)
	);

	initial begin
		data_clk_div = 1'b0;
		forever #2 data_clk_div = ~data_clk_div;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_word(input string name, input WORD_T exp, input WORD_T act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			fail_run("word mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %b actual %b", name, exp, act);
			fail_run("flag mismatch");
		end
	endtask

	always @(posedge data_clk_div) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout, the run took longer than %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	// enable seen three edges late, pair of this edge goes to the next address
	always @(posedge data_clk_div) begin
		in_reset <= rst;
		if (rst) begin
			en_hist = '0;
			en_delayed_prev = 1'b0;
			wr_ptr = 0;
			last_written = 1'b0;
			model_done = 1'b0;
		end else begin
			en_delayed = en_hist[2];
			if (!en_delayed) begin
				wr_ptr = 0;
				last_written = 1'b0;
				model_done = 1'b0;
			end else begin
				if (!en_delayed_prev) begin
					prev_mem = model_mem;
				end
				if (last_written) begin
					model_done = 1'b1;
					last_written = 1'b0;
				end
				if (wr_ptr < DEPTH) begin
					model_mem[wr_ptr] = {adc0_data, adc1_data};
					if (wr_ptr == DEPTH - 1) begin
						last_written = 1'b1;
					end
					wr_ptr++;
				end
			end
			en_delayed_prev = en_delayed;
			en_hist = {en_hist[1:0], capture_enable};
		end
	end

	// new samples every cycle
	always @(negedge data_clk_div) begin
		adc0_data <= SAMPLE_T'($urandom);
		adc1_data <= SAMPLE_T'($urandom);
		check_flag("capture_done", model_done, capture_done);
	end

	// consumer: response check, credit return and credit model
	always @(negedge data_clk_div) begin
		ADDR_T a;
		WORD_T exp;
		if (in_reset) begin
			model_credits = RSP_CREDITS;
			credit_due.delete();
			unreturned = 0;
			rsp_credit = 1'b0;
		end else begin
			if (model_credits == 0) begin
				check_flag("ready_without_credit", 1'b0, rd_req_ready);
			end
			if (rsp_valid) begin
				if (addr_fifo.size() == 0) begin
					fail_run("a response arrived without a pending request");
				end
				a = addr_fifo.pop_front();
				exp = model_mem[a];
				// mid-capture reads may still see the old word
				if (loose_check && rsp_data === prev_mem[a]) begin
					exp = prev_mem[a];
				end
				check_word(rd_name, exp, rsp_data);
				responses++;
				unreturned++;
				if (unreturned > RSP_CREDITS) begin
					fail_run("more responses outstanding than credits exist");
				end
				credit_due.push_back(cycle + int'($urandom_range(5, 0)));
			end
			if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cycle) begin
				void'(credit_due.pop_front());
				rsp_credit = 1'b1;
				unreturned--;
			end else begin
				rsp_credit = 1'b0;
			end
			model_credits = model_credits - int'(rsp_valid) + int'(rsp_credit);
		end
	end

	// called on a falling edge, returns on a falling edge
	task automatic issue_read(input ADDR_T addr);
		rd_req_valid = 1'b1;
		rd_addr = addr;
		while (!rd_req_ready) begin
			@(negedge data_clk_div);
		end
		addr_fifo.push_back(addr);
		accepted++;
		@(negedge data_clk_div);
		rd_req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (responses != accepted) begin
			@(negedge data_clk_div);
		end
	endtask

	// gives up after max_cycles so that a lost response shows up in the count
	task automatic wait_responses(input int max_cycles);
		int n;
		n = 0;
		while (responses != accepted && n < max_cycles) begin
			@(negedge data_clk_div);
			n++;
		end
	endtask

	task automatic read_all(input string name);
		rd_name = name;
		for (int i = 0; i < DEPTH; i++) begin
			issue_read(ADDR_T'(i));
		end
		wait_drain();
	endtask

	task automatic wait_done();
		while (!capture_done) begin
			@(negedge data_clk_div);
		end
	endtask

	initial begin
		int gap;
		rst = 1'b1;
		capture_enable = 1'b0;
		rd_req_valid = 1'b0;
		rd_addr = '0;
		hold_credits = 1'b0;
		loose_check = 1'b0;
		accepted = 0;
		responses = 0;
		cycle = 0;
		rd_name = "idle";
		void'($urandom(SEED));
		repeat (8) @(posedge data_clk_div);
		@(negedge data_clk_div);
		rst = 1'b0;
		@(negedge data_clk_div);
		check_flag("reset_capture_done", 1'b0, capture_done);
		check_flag("reset_rsp_valid", 1'b0, rsp_valid);
		check_flag("reset_rd_req_ready", 1'b1, rd_req_ready);

		capture_enable = 1'b1;
		wait_done();
		read_all("full_capture");

		// drop the enable part way through a capture
		capture_enable = 1'b0;
		repeat (10) @(negedge data_clk_div);
		capture_enable = 1'b1;
		gap = int'($urandom_range(900, 20));
		repeat (gap) @(negedge data_clk_div);
		capture_enable = 1'b0;
		repeat (10) @(negedge data_clk_div);
		check_flag("aborted_capture_done", 1'b0, capture_done);
		read_all("aborted_capture");

		capture_enable = 1'b1;
		wait_done();
		read_all("rearm_capture");
		capture_enable = 1'b0;
		repeat (10) @(negedge data_clk_div);

		// withhold credits until the engine runs dry
		while (model_credits != RSP_CREDITS) @(negedge data_clk_div);
		hold_credits = 1'b1;
		rd_name = "credit_limit";
		for (int i = 0; i < RSP_CREDITS; i++) begin
			issue_read(ADDR_T'($urandom));
		end
		wait_drain();
		check_flag("credit_limit_ready", 1'b0, rd_req_ready);
		rd_req_valid = 1'b1;
		rd_addr = ADDR_T'($urandom);
		repeat (10) begin
			@(negedge data_clk_div);
			check_flag("credit_limit_ready", 1'b0, rd_req_ready);
		end
		rd_req_valid = 1'b0;
		hold_credits = 1'b0;
		while (model_credits != RSP_CREDITS) @(negedge data_clk_div);

		loose_check = 1'b1;
		rd_name = "reads_during_capture";
		capture_enable = 1'b1;
		repeat (2) @(negedge data_clk_div);
		for (int i = 0; i < N_BUSY_READS; i++) begin
			issue_read(ADDR_T'($urandom));
		end
		wait_done();
		wait_responses(N_BUSY_READS * 20);
		check_flag("reads_during_capture_count", 1'b1, responses == accepted);
		loose_check = 1'b0;
		capture_enable = 1'b0;
		repeat (10) @(negedge data_clk_div);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
